/* source/bus_pkg.sv */
package bus_pkg;

    // word and address sizes of the shared bus
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 12;   // 4096 words per slave

    localparam int SLAVE_COUNT  = 2;
    localparam int MASTER_COUNT = 2;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [$clog2(SLAVE_COUNT)-1:0]  slave_id_t;
    typedef logic [$clog2(MASTER_COUNT)-1:0] master_id_t;

    // direction of a burst, seen from the master
    typedef enum logic {
        op_read,
        op_write
    } bus_op_t;

    typedef enum logic [1:0] {
        m_idle,       // waiting for a command
        m_request,    // req raised, no grant yet
        m_beat,       // one beat on the bus at a time
        m_done        // one-cycle completion pulse
    } master_state_t;

    typedef enum logic [1:0] {
        s_idle,
        s_wait,       // programmable wait cycles
        s_respond
    } slave_state_t;

endpackage

/* source/bus_master.sv */
module bus_master #(
    parameter int LOCAL_DEPTH = 16,
    parameter int SLAVE_DEPTH = 4096
) (
    input  logic                               clk,
    input  logic                               rstN,
    // command
    input  logic                               cmd_valid,
    input  bus_pkg::bus_op_t                   cmd_op,
    input  bus_pkg::slave_id_t                 cmd_slave,
    input  bus_pkg::addr_t                     cmd_addr,
    input  logic [$clog2(LOCAL_DEPTH+1)-1:0]   cmd_len,
    output logic                               cmd_ready,
    output logic                               done,
    // local buffer access
    input  logic                               load_en,
    input  logic [$clog2(LOCAL_DEPTH)-1:0]     load_addr,
    input  bus_pkg::data_t                     load_data,
    input  logic [$clog2(LOCAL_DEPTH)-1:0]     peek_addr,
    output bus_pkg::data_t                     peek_data,
    // arbiter
    output logic                               req,
    input  logic                               grant,
    // bus
    output logic                               m_valid,
    output bus_pkg::bus_op_t                   m_op,
    output bus_pkg::slave_id_t                 m_slave,
    output bus_pkg::addr_t                     m_addr,
    output bus_pkg::data_t                     m_wdata,
    input  logic                               m_ready,
    input  bus_pkg::data_t                     m_rdata
);

    localparam int IDX_W = $clog2(LOCAL_DEPTH);
    localparam int LEN_W = $clog2(LOCAL_DEPTH+1);

    bus_pkg::master_state_t state;
    bus_pkg::data_t         local_mem [LOCAL_DEPTH];

    logic [IDX_W-1:0]   beat;        // index of the beat on the bus
    bus_pkg::bus_op_t   op_q;
    bus_pkg::slave_id_t slave_q;
    bus_pkg::addr_t     addr_q;
    logic [LEN_W-1:0]   len_q;
    logic               accept, last_beat;

    assign cmd_ready = (state == bus_pkg::m_idle) || (state == bus_pkg::m_done);
    assign done      = (state == bus_pkg::m_done);
    assign req       = (state == bus_pkg::m_request) || (state == bus_pkg::m_beat);
    assign accept    = cmd_valid && cmd_ready;
    assign last_beat = (LEN_W'(beat) == len_q - 1'b1);

    // grant is held for the whole burst, so the beat state alone marks valid
    assign m_valid = (state == bus_pkg::m_beat);
    assign m_op    = op_q;
    assign m_slave = slave_q;
    assign m_addr  = bus_pkg::addr_t'((int'(addr_q) + int'(beat)) % SLAVE_DEPTH);
    assign m_wdata = local_mem[beat];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= bus_pkg::m_idle;
            beat  <= '0;
        end else begin
            case (state)
                bus_pkg::m_idle, bus_pkg::m_done: begin
                    if (accept) begin
                        state <= bus_pkg::m_request;
                        beat  <= '0;
                    end else begin
                        state <= bus_pkg::m_idle;
                    end
                end
                bus_pkg::m_request: begin
                    if (grant) state <= bus_pkg::m_beat;
                end
                bus_pkg::m_beat: begin
                    if (m_ready) begin
                        if (last_beat) state <= bus_pkg::m_done;
                        else beat <= beat + 1'b1;   // next beat goes out next cycle
                    end
                end
                default: state <= bus_pkg::m_idle;
            endcase
        end
    end

    // command fields, captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cmd_op;
            slave_q <= cmd_slave;
            addr_q  <= cmd_addr;
            len_q   <= cmd_len;
        end
    end

    // read beats and the load port never collide, loads need cmd_ready
    always_ff @(posedge clk) begin
        if (state == bus_pkg::m_beat && m_ready && op_q == bus_pkg::op_read)
            local_mem[beat] <= m_rdata;
        else if (load_en && cmd_ready)
            local_mem[load_addr] <= load_data;
        peek_data <= local_mem[peek_addr];
    end

endmodule

/* source/bus_arbiter.sv */
module bus_arbiter (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [bus_pkg::MASTER_COUNT-1:0]  req,
    output logic [bus_pkg::MASTER_COUNT-1:0]  grant
);

    bus_pkg::master_id_t owner;   // holder of the bus while busy
    bus_pkg::master_id_t ptr;     // highest priority for the next grant
    bus_pkg::master_id_t pick;
    logic                busy;
    logic                found;

    // first requester at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = ptr;
        for (int k = 0; k < bus_pkg::MASTER_COUNT; k++) begin
            idx = (int'(ptr) + k) % bus_pkg::MASTER_COUNT;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = bus_pkg::master_id_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            owner <= '0;
            ptr   <= '0;
        end else if (busy) begin
            if (!req[owner]) begin   // burst finished, rotate priority
                busy <= 1'b0;
                ptr  <= bus_pkg::master_id_t'((int'(owner) + 1) % bus_pkg::MASTER_COUNT);
            end
        end else if (found) begin
            busy  <= 1'b1;
            owner <= pick;
        end
    end

    always_comb begin
        grant = '0;
        if (busy) grant[owner] = 1'b1;
    end

endmodule

/* source/bus_interconnect.sv */
module bus_interconnect (
    input  logic [bus_pkg::MASTER_COUNT-1:0]                        grant,
    // master side
    input  logic [bus_pkg::MASTER_COUNT-1:0]                        m_valid,
    input  bus_pkg::bus_op_t   [bus_pkg::MASTER_COUNT-1:0]          m_op,
    input  bus_pkg::slave_id_t [bus_pkg::MASTER_COUNT-1:0]          m_slave,
    input  bus_pkg::addr_t     [bus_pkg::MASTER_COUNT-1:0]          m_addr,
    input  bus_pkg::data_t     [bus_pkg::MASTER_COUNT-1:0]          m_wdata,
    output logic [bus_pkg::MASTER_COUNT-1:0]                        m_ready,
    output bus_pkg::data_t     [bus_pkg::MASTER_COUNT-1:0]          m_rdata,
    // slave side
    output logic [bus_pkg::SLAVE_COUNT-1:0]                         s_valid,
    output bus_pkg::bus_op_t                                        bus_op,
    output bus_pkg::addr_t                                          bus_addr,
    output bus_pkg::data_t                                          bus_wdata,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]                         s_ready,
    input  bus_pkg::data_t     [bus_pkg::SLAVE_COUNT-1:0]           s_rdata
);

    bus_pkg::master_id_t sel;   // granted master
    bus_pkg::slave_id_t  slv;   // slave it addresses
    logic                any;

    always_comb begin
        sel = '0;
        any = 1'b0;
        for (int i = 0; i < bus_pkg::MASTER_COUNT; i++) begin
            if (grant[i]) begin
                sel = bus_pkg::master_id_t'(i);
                any = 1'b1;
            end
        end
    end

    assign slv       = m_slave[sel];
    assign bus_op    = m_op[sel];
    assign bus_addr  = m_addr[sel];
    assign bus_wdata = m_wdata[sel];

    // only the granted master and its selected slave see the handshake
    always_comb begin
        s_valid = '0;
        m_ready = '0;
        m_rdata = '0;
        if (any) begin
            s_valid[slv] = m_valid[sel];
            m_ready[sel] = s_ready[slv];
            m_rdata[sel] = s_rdata[slv];
        end
    end

endmodule

/* source/bus_memory_slave.sv */
module bus_memory_slave #(
    parameter int SLAVE_DEPTH = 4096,
    parameter int SLAVE_DELAY = 0
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             s_valid,
    input  bus_pkg::bus_op_t bus_op,
    input  bus_pkg::addr_t   bus_addr,
    input  bus_pkg::data_t   bus_wdata,
    output logic             s_ready,
    output bus_pkg::data_t   s_rdata
);

    localparam int AW = $clog2(SLAVE_DEPTH);
    localparam int CW = (SLAVE_DELAY > 0) ? $clog2(SLAVE_DELAY + 1) : 1;

    bus_pkg::slave_state_t state;
    bus_pkg::data_t        mem [SLAVE_DEPTH];
    logic [CW-1:0]         wait_cnt;
    logic                  go;     // access happens on this edge

    assign go = (state == bus_pkg::s_idle && s_valid && SLAVE_DELAY == 0) ||
                (state == bus_pkg::s_wait && int'(wait_cnt) == SLAVE_DELAY - 1);

    assign s_ready = (state == bus_pkg::s_respond);   // one cycle per beat

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= bus_pkg::s_idle;
            wait_cnt <= '0;
        end else begin
            case (state)
                bus_pkg::s_idle: begin
                    wait_cnt <= '0;
                    if (go) state <= bus_pkg::s_respond;
                    else if (s_valid) state <= bus_pkg::s_wait;
                end
                bus_pkg::s_wait: begin
                    if (go) state <= bus_pkg::s_respond;
                    else wait_cnt <= wait_cnt + 1'b1;
                end
                bus_pkg::s_respond: state <= bus_pkg::s_idle;  // master moves on next cycle
                default: state <= bus_pkg::s_idle;
            endcase
        end
    end

    // write, or registered read ready in the respond cycle
    always_ff @(posedge clk) begin
        if (go) begin
            if (bus_op == bus_pkg::op_write)
                mem[bus_addr[AW-1:0]] <= bus_wdata;
            else
                s_rdata <= mem[bus_addr[AW-1:0]];
        end
    end

endmodule

/* source/bus_system_top.sv */
module bus_system_top #(
    parameter int LOCAL_DEPTH  = 16,
    parameter int SLAVE_DEPTH  = 4096,
    parameter int SLAVE0_DELAY = 0,
    parameter int SLAVE1_DELAY = 5
) (
    input  logic                                                          clk,
    input  logic                                                          rstN,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                              cmd_valid,
    output logic [bus_pkg::MASTER_COUNT-1:0]                              cmd_ready,
    input  bus_pkg::bus_op_t   [bus_pkg::MASTER_COUNT-1:0]                cmd_op,
    input  bus_pkg::slave_id_t [bus_pkg::MASTER_COUNT-1:0]                cmd_slave,
    input  bus_pkg::addr_t     [bus_pkg::MASTER_COUNT-1:0]                cmd_addr,
    input  logic [bus_pkg::MASTER_COUNT-1:0][$clog2(LOCAL_DEPTH+1)-1:0]   cmd_len,
    output logic [bus_pkg::MASTER_COUNT-1:0]                              done,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                              load_en,
    input  logic [bus_pkg::MASTER_COUNT-1:0][$clog2(LOCAL_DEPTH)-1:0]     load_addr,
    input  bus_pkg::data_t     [bus_pkg::MASTER_COUNT-1:0]                load_data,
    input  logic [bus_pkg::MASTER_COUNT-1:0][$clog2(LOCAL_DEPTH)-1:0]     peek_addr,
    output bus_pkg::data_t     [bus_pkg::MASTER_COUNT-1:0]                peek_data
);

    localparam int MC = bus_pkg::MASTER_COUNT;
    localparam int SC = bus_pkg::SLAVE_COUNT;

    logic [MC-1:0]                req, grant;
    logic [MC-1:0]                m_valid, m_ready;
    bus_pkg::bus_op_t   [MC-1:0]  m_op;
    bus_pkg::slave_id_t [MC-1:0]  m_slave;
    bus_pkg::addr_t     [MC-1:0]  m_addr;
    bus_pkg::data_t     [MC-1:0]  m_wdata, m_rdata;

    logic [SC-1:0]                s_valid, s_ready;
    bus_pkg::data_t     [SC-1:0]  s_rdata;
    bus_pkg::bus_op_t             bus_op;
    bus_pkg::addr_t               bus_addr;
    bus_pkg::data_t               bus_wdata;

    for (genvar g = 0; g < MC; g++) begin : g_master
        bus_master #(.LOCAL_DEPTH(LOCAL_DEPTH), .SLAVE_DEPTH(SLAVE_DEPTH)) u_master (
            .clk, .rstN,
            .cmd_valid (cmd_valid[g]), .cmd_op    (cmd_op[g]),
            .cmd_slave (cmd_slave[g]), .cmd_addr  (cmd_addr[g]),
            .cmd_len   (cmd_len[g]),   .cmd_ready (cmd_ready[g]),
            .done      (done[g]),
            .load_en   (load_en[g]),   .load_addr (load_addr[g]),
            .load_data (load_data[g]), .peek_addr (peek_addr[g]),
            .peek_data (peek_data[g]),
            .req       (req[g]),       .grant     (grant[g]),
            .m_valid   (m_valid[g]),   .m_op      (m_op[g]),
            .m_slave   (m_slave[g]),   .m_addr    (m_addr[g]),
            .m_wdata   (m_wdata[g]),   .m_ready   (m_ready[g]),
            .m_rdata   (m_rdata[g])
        );
    end

    bus_arbiter u_arbiter (.clk, .rstN, .req, .grant);

    bus_interconnect u_interconnect (
        .grant, .m_valid, .m_op, .m_slave, .m_addr, .m_wdata, .m_ready, .m_rdata,
        .s_valid, .bus_op, .bus_addr, .bus_wdata, .s_ready, .s_rdata
    );

    // slave 1 is the slow one by default
    for (genvar g = 0; g < SC; g++) begin : g_slave
        bus_memory_slave #(
            .SLAVE_DEPTH (SLAVE_DEPTH),
            .SLAVE_DELAY ((g == 0) ? SLAVE0_DELAY : SLAVE1_DELAY)
        ) u_slave (
            .clk, .rstN,
            .s_valid   (s_valid[g]),
            .bus_op, .bus_addr, .bus_wdata,
            .s_ready   (s_ready[g]),
            .s_rdata   (s_rdata[g])
        );
    end

endmodule

/* bench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // period 40
    end

    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* bench/tb_top.sv */
module tb_top;

    localparam int MC          = bus_pkg::MASTER_COUNT;
    localparam int LOCAL_DEPTH = 16;
    localparam int SLAVE_DEPTH = 4096;
    localparam int IW          = $clog2(LOCAL_DEPTH);
    localparam int TIMEOUT     = 1000;   // cycles allowed per wait

    logic clk, rstN;

    logic [MC-1:0]                           cmd_valid, cmd_ready, done, load_en;
    bus_pkg::bus_op_t   [MC-1:0]             cmd_op;
    bus_pkg::slave_id_t [MC-1:0]             cmd_slave;
    bus_pkg::addr_t     [MC-1:0]             cmd_addr;
    logic [MC-1:0][$clog2(LOCAL_DEPTH+1)-1:0] cmd_len;
    logic [MC-1:0][IW-1:0]                   load_addr, peek_addr, peek_addr_d;
    bus_pkg::data_t     [MC-1:0]             load_data, peek_data;

    // reference model of both slave memories and both local buffers
    bus_pkg::data_t slave_model [bus_pkg::SLAVE_COUNT][SLAVE_DEPTH];
    bus_pkg::data_t local_model [MC][LOCAL_DEPTH];
    logic           peek_on;
    integer         seed;

    clock_gen u_clock (.clk, .rstN);

    bus_system_top dut (
        .clk, .rstN, .cmd_valid, .cmd_ready, .cmd_op, .cmd_slave, .cmd_addr, .cmd_len,
        .done, .load_en, .load_addr, .load_data, .peek_addr, .peek_data
    );

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // slave word seen by beat i of a read burst
    function automatic bus_pkg::data_t expected_read(input int s, input int addr, input int i);
        return slave_model[s][(addr + i) % SLAVE_DEPTH];
    endfunction

    task automatic apply_model(input int m, input bus_pkg::bus_op_t op, input int s,
                               input int addr, input int len);
        for (int i = 0; i < len; i++) begin
            if (op == bus_pkg::op_write)
                slave_model[s][(addr + i) % SLAVE_DEPTH] = local_model[m][i];
            else
                local_model[m][i] = expected_read(s, addr, i);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rstN && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rstN) begin
            $display("timeout waiting for reset release");
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic wait_ready(input int m);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cmd_ready[m] && cycles < TIMEOUT);
        if (!cmd_ready[m]) begin
            $display("timeout waiting for cmd_ready on master %0d", m);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // cmd_ready must stay low until the done pulse, and come back with it
    task automatic wait_done(input logic [MC-1:0] mask);
        logic [MC-1:0] seen;
        int            cycles;
        seen   = '0;
        cycles = 0;
        while (seen != mask && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            for (int m = 0; m < MC; m++) begin
                if (mask[m] && !seen[m]) begin
                    seen[m] = done[m];
                    check($sformatf("cmd_ready[%0d]", m), done[m], cmd_ready[m]);
                end
            end
        end
        if (seen != mask) begin
            $display("timeout waiting for done, master mask %b", mask);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic drive_cmd(input int m, input bus_pkg::bus_op_t op, input int s,
                             input int addr, input int len);
        cmd_valid[m] <= 1'b1;
        cmd_op[m]    <= op;
        cmd_slave[m] <= bus_pkg::slave_id_t'(s);
        cmd_addr[m]  <= bus_pkg::addr_t'(addr);
        cmd_len[m]   <= len;
    endtask

    task automatic run_cmd(input int m, input bus_pkg::bus_op_t op, input int s,
                           input int addr, input int len);
        wait_ready(m);
        @(posedge clk);
        drive_cmd(m, op, s, addr, len);
        @(posedge clk);
        cmd_valid[m] <= 1'b0;     // accepted on this edge
        wait_done(m ? 2'b10 : 2'b01);
        apply_model(m, op, s, addr, len);
    endtask

    task automatic load_random(input int m, input int n);
        bus_pkg::data_t v;
        for (int i = 0; i < n; i++) begin
            v = $random(seed);
            @(posedge clk);
            load_en[m]   <= 1'b1;
            load_addr[m] <= i;
            load_data[m] <= v;
            local_model[m][i] = v;
        end
        @(posedge clk);
        load_en[m] <= 1'b0;
    endtask

    // walk every buffer word past the compare process
    task automatic verify_buffer(input int m);
        for (int i = 0; i < LOCAL_DEPTH; i++) begin
            @(posedge clk);
            peek_addr[m] <= i;
            peek_on = 1'b1;
        end
        repeat (2) @(posedge clk);
        peek_on = 1'b0;
    endtask

    always @(posedge clk) peek_addr_d <= peek_addr;   // peek has one cycle latency

    always @(negedge clk) begin
        if (peek_on) begin
            for (int m = 0; m < MC; m++)
                check($sformatf("peek_data[%0d]", m), local_model[m][peek_addr_d[m]],
                      peek_data[m]);
        end
    end

    initial begin
        int               m, s, addr, len;
        bus_pkg::bus_op_t op;
        seed      = 2;
        peek_on   = 1'b0;
        cmd_valid = '0;
        cmd_slave = '0;
        cmd_addr  = '0;
        cmd_len   = '0;
        load_en   = '0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        for (int i = 0; i < MC; i++) cmd_op[i] = bus_pkg::op_read;

        wait_reset();
        @(negedge clk);
        check("done", 2'b00, done);
        check("cmd_ready", 2'b11, cmd_ready);
        load_random(0, LOCAL_DEPTH);
        load_random(1, LOCAL_DEPTH);

        // write through master 0 and read back through master 1
        load_random(0, 8);
        run_cmd(0, bus_pkg::op_write, 0, 100, 8);
        run_cmd(1, bus_pkg::op_read, 0, 100, 8);
        verify_buffer(1);

        // both masters start in the same cycle on the slow slave
        load_random(0, 8);
        load_random(1, 8);
        for (int pass = 0; pass < 2; pass++) begin
            op = pass ? bus_pkg::op_read : bus_pkg::op_write;
            wait_ready(0);
            wait_ready(1);
            @(posedge clk);
            drive_cmd(0, op, 1, pass ? 500 : 300, 8);
            drive_cmd(1, op, 1, pass ? 300 : 500, 8);
            @(posedge clk);
            cmd_valid <= '0;
            wait_done(2'b11);
            apply_model(0, op, 1, pass ? 500 : 300, 8);
            apply_model(1, op, 1, pass ? 300 : 500, 8);
        end
        verify_buffer(0);
        verify_buffer(1);

        // burst across the top of the slave address space
        load_random(0, 4);
        run_cmd(0, bus_pkg::op_write, 0, 4094, 4);
        run_cmd(1, bus_pkg::op_read, 0, 4094, 4);
        run_cmd(0, bus_pkg::op_read, 0, 0, 2);
        verify_buffer(1);
        verify_buffer(0);

        // loads while busy must not reach the buffer
        wait_ready(0);
        @(posedge clk);
        drive_cmd(0, bus_pkg::op_write, 1, 700, LOCAL_DEPTH);
        @(posedge clk);
        cmd_valid[0] <= 1'b0;
        fork
            wait_done(2'b01);
            begin
                for (int i = 0; i < 4; i++) begin
                    @(posedge clk);
                    load_en[0]   <= 1'b1;
                    load_addr[0] <= i;
                    load_data[0] <= ~local_model[0][i];
                end
                @(posedge clk);
                load_en[0] <= 1'b0;
                verify_buffer(0);
            end
        join
        apply_model(0, bus_pkg::op_write, 1, 700, LOCAL_DEPTH);

        // known contents for the random window before random traffic
        for (int i = 0; i < 10; i++) begin
            load_random(0, LOCAL_DEPTH);
            run_cmd(0, bus_pkg::op_write, i / 5, 200 + 16 * (i % 5), LOCAL_DEPTH);
        end
        for (int k = 0; k < 40; k++) begin
            m    = $random(seed) & 1;
            s    = $random(seed) & 1;
            op   = bus_pkg::bus_op_t'($random(seed) & 1);
            len  = ($random(seed) & 15) + 1;
            addr = 200 + ($random(seed) & 63);
            if (op == bus_pkg::op_write) load_random(m, len);
            run_cmd(m, op, s, addr, len);
            verify_buffer(m);
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* tb.f */
source/bus_pkg.sv
source/bus_master.sv
source/bus_arbiter.sv
source/bus_interconnect.sv
source/bus_memory_slave.sv
source/bus_system_top.sv
bench/clock_gen.sv
bench/tb_top.sv

/* Bender.yml */
package:
  name: bus_system

sources:
  - files:
      - source/bus_pkg.sv
      - source/bus_master.sv
      - source/bus_arbiter.sv
      - source/bus_interconnect.sv
      - source/bus_memory_slave.sv
      - source/bus_system_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_top.sv
